// ==== design/swu_pkg.sv ====
package swu_pkg;

   //////////////////////////////////////////////////
   // default geometry
   //////////////////////////////////////////////////

   localparam int IFM_WIDTH    = 5;
   localparam int IFM_HEIGHT   = 5;
   localparam int CHANNELS     = 4;
   localparam int SIMD         = 2;
   localparam int PRECISION    = 4;
   localparam int KERNEL       = 3;
   localparam int STRIDE       = 1;
   // needs (KERNEL-1)*IFM_WIDTH*FOLDS + KERNEL*FOLDS words at least
   localparam int BUFFER_DEPTH = 32;

   //////////////////////////////////////////////////
   // derived constants
   //////////////////////////////////////////////////

   localparam int FOLDS       = CHANNELS / SIMD;
   localparam int OFM_WIDTH   = (IFM_WIDTH - KERNEL) / STRIDE + 1;
   localparam int OFM_HEIGHT  = (IFM_HEIGHT - KERNEL) / STRIDE + 1;
   localparam int FRAME_WORDS = IFM_WIDTH * IFM_HEIGHT * FOLDS;

   // one stream word holds SIMD channels
   typedef logic [SIMD*PRECISION-1:0] swu_word_t;

   // word index inside one frame
   typedef logic [15:0] swu_index_t;

   typedef logic [$clog2(BUFFER_DEPTH)-1:0] swu_addr_t;

   typedef enum logic {
      FILL,
      DRAIN
   } swu_wr_state_e;

endpackage

// ==== design/swu_rd_if.sv ====
`timescale 1ns/1ns

// read side of the window buffer
interface swu_rd_if import swu_pkg::*; ();

   logic       rd_en;
   swu_index_t rd_index;
   // words below this index are free for overwrite
   swu_index_t release_count;

   // data lags rd_en by one cycle
   swu_word_t  rd_data;
   swu_index_t written_count;

   modport reader (
      output rd_en,
      output rd_index,
      output release_count,
      input  rd_data,
      input  written_count
   );

   modport buffer (
      input  rd_en,
      input  rd_index,
      input  release_count,
      output rd_data,
      output written_count
   );

endinterface

// ==== design/swu_pixel_writer.sv ====
`timescale 1ns/1ns

module swu_pixel_writer import swu_pkg::*; #(
   parameter int FRAME_WORDS = swu_pkg::FRAME_WORDS
) (
   input  logic      clk,
   input  logic      resetn,
   input  swu_word_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   input  logic      space_i,
   input  logic      frame_done_i,
   output logic      wr_en_o,
   output swu_word_t wr_data_o
);

   localparam swu_index_t LAST_WORD = swu_index_t'(FRAME_WORDS - 1);

   swu_wr_state_e state_q;
   swu_index_t    count_q;

   assign in_ready_o = (state_q == FILL) && space_i;
   assign wr_en_o    = in_valid_i && in_ready_o;
   assign wr_data_o  = in_data_i;

   //////////////////////////////////////////////////
   // frame FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         state_q <= DRAIN;
         count_q <= '0;
      end else begin
         case (state_q)
            FILL: begin
               if (wr_en_o) begin
                  count_q <= count_q + 1'b1;
                  if (count_q == LAST_WORD) begin
                     state_q <= DRAIN;
                  end
               end
            end
            DRAIN: begin
               // zero count only happens straight out of reset
               if (frame_done_i || count_q == '0) begin
                  state_q <= FILL;
                  count_q <= '0;
               end
            end
            default: state_q <= DRAIN;
         endcase
      end
   end

endmodule

// ==== design/swu_window_buffer.sv ====
`timescale 1ns/1ns

module swu_window_buffer import swu_pkg::*; #(
   parameter int BUFFER_DEPTH = swu_pkg::BUFFER_DEPTH
) (
   input  logic            clk,
   input  logic            resetn,
   input  logic            wr_en_i,
   input  swu_word_t       wr_data_i,
   output logic            space_o,
   input  logic            frame_done_i,
   swu_rd_if.buffer        rd
);

   swu_word_t  mem [BUFFER_DEPTH];
   swu_index_t written_q;
   swu_index_t occupancy;
   swu_addr_t  wr_addr;
   swu_addr_t  rd_addr;

   // circular addressing, word index modulo depth
   assign wr_addr = swu_addr_t'(written_q % BUFFER_DEPTH);
   assign rd_addr = swu_addr_t'(rd.rd_index % BUFFER_DEPTH);

   //////////////////////////////////////////////////
   // fill level
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         written_q <= '0;
      end else if (wr_en_i) begin
         written_q <= written_q + 1'b1;
      end
   end

   assign rd.written_count = written_q;

   // words still held for the reader
   assign occupancy = written_q - rd.release_count;
   assign space_o   = occupancy < swu_index_t'(BUFFER_DEPTH);

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr] <= wr_data_i;
      end
   end

   // rd_data holds between reads, the output stage relies on it
   always_ff @(posedge clk) begin
      if (rd.rd_en) begin
         rd.rd_data <= mem[rd_addr];
      end
   end

endmodule

// ==== design/swu_window_reader.sv ====
`timescale 1ns/1ns

module swu_window_reader import swu_pkg::*; #(
   parameter int IFM_WIDTH    = swu_pkg::IFM_WIDTH,
   parameter int IFM_HEIGHT   = swu_pkg::IFM_HEIGHT,
   parameter int FOLDS        = swu_pkg::FOLDS,
   parameter int KERNEL       = swu_pkg::KERNEL,
   parameter int STRIDE       = swu_pkg::STRIDE,
   parameter int BUFFER_DEPTH = swu_pkg::BUFFER_DEPTH
) (
   input  logic      clk,
   input  logic      resetn,
   swu_rd_if.reader  rd,
   input  logic      stage_ready_i,
   input  logic      frame_done_i,
   output logic      issue_o,
   output logic      issue_last_o
);

   localparam int OUT_W = (IFM_WIDTH - KERNEL) / STRIDE + 1;
   localparam int OUT_H = (IFM_HEIGHT - KERNEL) / STRIDE + 1;

   localparam swu_index_t LAST_F    = swu_index_t'(FOLDS - 1);
   localparam swu_index_t LAST_K    = swu_index_t'(KERNEL - 1);
   localparam swu_index_t LAST_OX   = swu_index_t'(OUT_W - 1);
   localparam swu_index_t LAST_OY   = swu_index_t'(OUT_H - 1);
   localparam swu_index_t PIX_STEP  = swu_index_t'(FOLDS);
   localparam swu_index_t ROW_WORDS = swu_index_t'(IFM_WIDTH * FOLDS);
   localparam swu_index_t COL_STEP  = swu_index_t'(STRIDE * FOLDS);
   localparam swu_index_t ROW_STEP  = swu_index_t'(STRIDE * IFM_WIDTH * FOLDS);

   swu_index_t f_q, kw_q, kh_q, ox_q, oy_q;
   // win_* mark the window origin, *_base the current kernel tap
   swu_index_t win_row_q, row_base_q;
   swu_index_t win_col_q, col_base_q;
   logic       done_q;
   swu_index_t word_idx;
   logic       last_word;
   logic       issue;

   assign word_idx  = row_base_q + col_base_q + f_q;
   assign last_word = (f_q == LAST_F) && (kw_q == LAST_K) && (kh_q == LAST_K) &&
                      (ox_q == LAST_OX) && (oy_q == LAST_OY);

   // word must already be written
   assign issue = !done_q && stage_ready_i && (word_idx < rd.written_count);

   assign issue_o          = issue;
   assign issue_last_o     = issue && last_word;
   assign rd.rd_en         = issue;
   assign rd.rd_index      = word_idx;
   assign rd.release_count = win_row_q;

   //////////////////////////////////////////////////
   // window walk: oy, ox, kh, kw, f
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         f_q        <= '0;
         kw_q       <= '0;
         kh_q       <= '0;
         ox_q       <= '0;
         oy_q       <= '0;
         win_row_q  <= '0;
         row_base_q <= '0;
         win_col_q  <= '0;
         col_base_q <= '0;
         done_q     <= 1'b0;
      end else if (issue) begin
         if (last_word) begin
            done_q <= 1'b1;
         end else if (f_q != LAST_F) begin
            f_q <= f_q + 1'b1;
         end else begin
            f_q <= '0;
            if (kw_q != LAST_K) begin
               kw_q       <= kw_q + 1'b1;
               col_base_q <= col_base_q + PIX_STEP;
            end else begin
               kw_q       <= '0;
               col_base_q <= win_col_q;
               if (kh_q != LAST_K) begin
                  kh_q       <= kh_q + 1'b1;
                  row_base_q <= row_base_q + ROW_WORDS;
               end else begin
                  kh_q       <= '0;
                  row_base_q <= win_row_q;
                  if (ox_q != LAST_OX) begin
                     ox_q       <= ox_q + 1'b1;
                     win_col_q  <= win_col_q + COL_STEP;
                     col_base_q <= win_col_q + COL_STEP;
                  end else begin
                     // next output row, rows above it are released
                     ox_q       <= '0;
                     win_col_q  <= '0;
                     col_base_q <= '0;
                     oy_q       <= oy_q + 1'b1;
                     win_row_q  <= win_row_q + ROW_STEP;
                     row_base_q <= win_row_q + ROW_STEP;
                  end
               end
            end
         end
      end
   end

endmodule

// ==== design/swu_output_stage.sv ====
`timescale 1ns/1ns

module swu_output_stage import swu_pkg::*; (
   input  logic      clk,
   input  logic      resetn,
   input  logic      issue_i,
   input  logic      issue_last_i,
   input  swu_word_t rd_data_i,
   output logic      stage_ready_o,
   output swu_word_t out_data_o,
   output logic      out_valid_o,
   output logic      out_last_o,
   input  logic      out_ready_i,
   output logic      frame_done_o
);

   logic rd_valid_q;
   logic rd_last_q;
   logic out_load;

   assign out_load      = !out_valid_o || out_ready_i;
   // no new read once both slots are taken
   assign stage_ready_o = !(rd_valid_q && out_valid_o);
   assign frame_done_o  = out_valid_o && out_ready_i && out_last_o;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_valid_q  <= 1'b0;
         rd_last_q   <= 1'b0;
         out_valid_o <= 1'b0;
         out_last_o  <= 1'b0;
      end else begin
         if (issue_i) begin
            rd_valid_q <= 1'b1;
            rd_last_q  <= issue_last_i;
         end else if (out_load) begin
            rd_valid_q <= 1'b0;
         end
         if (out_load) begin
            out_valid_o <= rd_valid_q;
            out_last_o  <= rd_valid_q && rd_last_q;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (out_load && rd_valid_q) begin
         out_data_o <= rd_data_i;
      end
   end

endmodule

// ==== design/swu_top.sv ====
`timescale 1ns/1ns

module swu_top import swu_pkg::*; #(
   parameter int IFM_WIDTH    = swu_pkg::IFM_WIDTH,
   parameter int IFM_HEIGHT   = swu_pkg::IFM_HEIGHT,
   parameter int FOLDS        = swu_pkg::FOLDS,
   parameter int KERNEL       = swu_pkg::KERNEL,
   parameter int STRIDE       = swu_pkg::STRIDE,
   parameter int BUFFER_DEPTH = swu_pkg::BUFFER_DEPTH
) (
   input  logic      clk,
   input  logic      resetn,
   input  swu_word_t in_data_i,
   input  logic      in_valid_i,
   output logic      in_ready_o,
   output swu_word_t out_data_o,
   output logic      out_valid_o,
   output logic      out_last_o,
   input  logic      out_ready_i
);

   localparam int FRAME_WORDS = IFM_WIDTH * IFM_HEIGHT * FOLDS;

   logic      wr_en;
   swu_word_t wr_data;
   logic      space;
   logic      issue;
   logic      issue_last;
   logic      stage_ready;
   logic      frame_done;

   swu_rd_if rd_bus ();

   //////////////////////////////////////////////////
   // ingress and storage
   //////////////////////////////////////////////////

   swu_pixel_writer #(
      .FRAME_WORDS (FRAME_WORDS)
   ) u_writer (
      .clk          (clk),
      .resetn       (resetn),
      .in_data_i    (in_data_i),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .space_i      (space),
      .frame_done_i (frame_done),
      .wr_en_o      (wr_en),
      .wr_data_o    (wr_data)
   );

   swu_window_buffer #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) u_buffer (
      .clk          (clk),
      .resetn       (resetn),
      .wr_en_i      (wr_en),
      .wr_data_i    (wr_data),
      .space_o      (space),
      .frame_done_i (frame_done),
      .rd           (rd_bus.buffer)
   );

   //////////////////////////////////////////////////
   // window replay and egress
   //////////////////////////////////////////////////

   swu_window_reader #(
      .IFM_WIDTH    (IFM_WIDTH),
      .IFM_HEIGHT   (IFM_HEIGHT),
      .FOLDS        (FOLDS),
      .KERNEL       (KERNEL),
      .STRIDE       (STRIDE),
      .BUFFER_DEPTH (BUFFER_DEPTH)
   ) u_reader (
      .clk           (clk),
      .resetn        (resetn),
      .rd            (rd_bus.reader),
      .stage_ready_i (stage_ready),
      .frame_done_i  (frame_done),
      .issue_o       (issue),
      .issue_last_o  (issue_last)
   );

   swu_output_stage u_out (
      .clk           (clk),
      .resetn        (resetn),
      .issue_i       (issue),
      .issue_last_i  (issue_last),
      .rd_data_i     (rd_bus.rd_data),
      .stage_ready_o (stage_ready),
      .out_data_o    (out_data_o),
      .out_valid_o   (out_valid_o),
      .out_last_o    (out_last_o),
      .out_ready_i   (out_ready_i),
      .frame_done_o  (frame_done)
   );

endmodule

// ==== tb/tb_swu_top.sv ====
`timescale 1ns/1ns

module tb_swu_top import swu_pkg::*; ();

   localparam int CLK_PERIOD     = 20;
   localparam int DRIVE_DELAY    = 2;
   localparam int IN_WORDS       = 50;
   localparam int OUT_WORDS      = 162;
   localparam int FRAMES         = 2;
   localparam int TIMEOUT_CYCLES = 40 * OUT_WORDS * FRAMES;

   logic      clk;
   logic      resetn;
   swu_word_t in_data_i;
   logic      in_valid_i;
   logic      in_ready_o;
   swu_word_t out_data_o;
   logic      out_valid_o;
   logic      out_last_o;
   logic      out_ready_i;

   // input words first, expected window words after them
   swu_word_t stim_mem [IN_WORDS + OUT_WORDS];

   integer    seed;
   int        in_count;
   int        out_pos;
   int        out_frames;
   logic      in_fire;
   logic      hold_pending;
   swu_word_t hold_data;

   swu_top UUT (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_last_o  (out_last_o),
      .out_ready_i (out_ready_i)
   );

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s expected 0x%0h, actual 0x%0h",
                  $time, name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: the DUT did not deliver both frames in time");
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////
   // stream drivers
   //////////////////////////////////////////////////

   // a pending input word stays on the bus until it is taken
   initial begin
      wait (resetn === 1'b1);
      forever begin
         @(posedge clk);
         #(DRIVE_DELAY);
         if (!in_valid_i || in_fire) begin
            // next frame only after the previous one came out
            if (in_count < IN_WORDS * (out_frames + 1) && in_count < IN_WORDS * FRAMES) begin
               in_valid_i = ($random(seed) & 3) != 0;
               in_data_i  = stim_mem[in_count % IN_WORDS];
            end else begin
               in_valid_i = 1'b0;
            end
         end
         out_ready_i = ($random(seed) & 3) != 0;
      end
   end

   //////////////////////////////////////////////////
   // monitor, samples mid-cycle
   //////////////////////////////////////////////////

   always @(negedge clk) begin
      if (resetn === 1'b1) begin
         if (hold_pending) begin
            check_value("out_valid_o", 1, out_valid_o);
            check_value("out_data_o", hold_data, out_data_o);
         end
         hold_pending = out_valid_o && !out_ready_i;
         hold_data    = out_data_o;

         // whole frame taken, ingress stays closed until the frame is out
         if (in_count == IN_WORDS * (out_frames + 1)) begin
            check_value("in_ready_o", 0, in_ready_o);
         end
         in_fire = in_valid_i && in_ready_o;
         if (in_fire) begin
            in_count++;
         end

         if (out_valid_o && out_ready_i) begin
            check_value("out_data_o", stim_mem[IN_WORDS + out_pos], out_data_o);
            check_value("out_last_o", out_pos == OUT_WORDS - 1, out_last_o);
            out_pos++;
            if (out_pos == OUT_WORDS) begin
               out_pos = 0;
               out_frames++;
            end
         end
      end
   end

   initial begin
      seed         = 32'h2834_4e14;
      resetn       = 1'b0;
      in_data_i    = '0;
      in_valid_i   = 1'b0;
      out_ready_i  = 1'b0;
      in_count     = 0;
      out_pos      = 0;
      out_frames   = 0;
      in_fire      = 1'b0;
      hold_pending = 1'b0;
      hold_data    = '0;
      $readmemh("tb/swu_stimulus.hex", stim_mem);

      repeat (2) @(posedge clk);
      #(DRIVE_DELAY);
      resetn = 1'b1;
      @(negedge clk);
      check_value("out_valid_o", 0, out_valid_o);
      check_value("out_last_o", 0, out_last_o);

      wait (out_frames == FRAMES);
      @(posedge clk);
      check_value("accepted input words", IN_WORDS * FRAMES, in_count);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== sources.f ====
design/swu_pkg.sv
design/swu_rd_if.sv
design/swu_pixel_writer.sv
design/swu_window_buffer.sv
design/swu_window_reader.sv
design/swu_output_stage.sv
design/swu_top.sv
tb/tb_swu_top.sv

// ==== Bender.yml ====
package:
  name: swu

sources:
  - files:
      - design/swu_pkg.sv
      - design/swu_rd_if.sv
      - design/swu_pixel_writer.sv
      - design/swu_window_buffer.sv
      - design/swu_window_reader.sv
      - design/swu_output_stage.sv
      - design/swu_top.sv
  - target: test
    files:
      - tb/tb_swu_top.sv

// ==== tb/swu_stimulus.hex ====
// lines 1-5: the 50 input words of one frame, word index order
// lines 6-14: expected output, one 3x3 window per line, kh kw f order
13 1a 21 28 2f 36 3d 44 4b 52
59 60 67 6e 75 7c 83 8a 91 98
9f a6 ad b4 bb c2 c9 d0 d7 de
e5 ec f3 fa 01 08 0f 16 1d 24
2b 32 39 40 47 4e 55 5c 63 6a
13 1a 21 28 2f 36 59 60 67 6e 75 7c 9f a6 ad b4 bb c2
21 28 2f 36 3d 44 67 6e 75 7c 83 8a ad b4 bb c2 c9 d0
2f 36 3d 44 4b 52 75 7c 83 8a 91 98 bb c2 c9 d0 d7 de
59 60 67 6e 75 7c 9f a6 ad b4 bb c2 e5 ec f3 fa 01 08
67 6e 75 7c 83 8a ad b4 bb c2 c9 d0 f3 fa 01 08 0f 16
75 7c 83 8a 91 98 bb c2 c9 d0 d7 de 01 08 0f 16 1d 24
9f a6 ad b4 bb c2 e5 ec f3 fa 01 08 2b 32 39 40 47 4e
ad b4 bb c2 c9 d0 f3 fa 01 08 0f 16 39 40 47 4e 55 5c
bb c2 c9 d0 d7 de 01 08 0f 16 1d 24 47 4e 55 5c 63 6a
